/* hdl/alfa_macros.svh */
// Widths, point layout and register map for the point-cloud access unit
// Included by the package and by every module that sizes ports or decodes registers

`ifndef ALFA_MACROS_SVH
`define ALFA_MACROS_SVH

// Data widths
`define ALFA_ID_W        19
`define ALFA_ADDR_W      32
`define ALFA_FIELD_W     16

// One point is a single 64-bit memory word
`define ALFA_POINT_BYTES 8

// Register offsets on the register bus
`define ALFA_REG_CTRL    4'h0
`define ALFA_REG_BASE    4'h4
`define ALFA_REG_SIZE    4'h8
`define ALFA_REG_STATUS  4'hC

`endif

/* hdl/alfa_pkg.sv */
// Shared types of the point-cloud access unit
// Point word layout, ID and address types, and the control FSM states

`default_nettype none

`include "alfa_macros.svh"

package alfa_pkg;

  // Memory word, high to low
  typedef struct packed {
    logic [`ALFA_FIELD_W-1:0] angle_h;
    logic [`ALFA_FIELD_W-1:0] angle_v;
    logic [`ALFA_FIELD_W-1:0] radius;
    logic [`ALFA_FIELD_W-1:0] custom;
  } point_t;

  typedef logic [`ALFA_ID_W-1:0]   point_id_t;
  typedef logic [`ALFA_ADDR_W-1:0] addr_t;

  typedef enum logic [3:0] {
    IDLE,
    RUN,
    RD_FETCH,
    RD_WAIT,
    RD_RESP,
    WR_FETCH,
    WR_WAIT,
    WR_STORE,
    WR_DONE_WAIT
  } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/alfa_monitor.sv */
// Software register file: CTRL, BASE, SIZE and read-only STATUS
// Writes and reads use one-cycle strobes; read data returns one cycle later

`timescale 1ns/1ns
`default_nettype none

`include "alfa_macros.svh"

module alfa_monitor (
  input  wire                   i_system_clk,
  input  wire                   i_rst_n,
  input  wire                   i_reg_wr,
  input  wire                   i_reg_rd,
  input  wire [3:0]             i_reg_addr,
  input  wire [31:0]            i_reg_wdata,
  input  wire                   i_frame_start,
  input  wire                   i_frame_done,
  input  wire                   i_enable,
  output logic [31:0]           o_reg_rdata,
  output logic                  o_reg_rvalid,
  output logic                  o_pc_ready,
  output alfa_pkg::addr_t       o_base_addr,
  output alfa_pkg::point_id_t   o_pc_size
);

  logic pc_ready_q;
  logic frame_done_q;
  alfa_pkg::addr_t base_q;
  alfa_pkg::point_id_t size_q;
  logic [31:0] rd_mux;

  always_ff @(posedge i_system_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_ready_q   <= 1'b0;
      frame_done_q <= 1'b0;
      base_q       <= '0;
      size_q       <= '0;
    end else begin
      if (i_reg_wr) begin
        case (i_reg_addr)
          `ALFA_REG_CTRL: pc_ready_q <= i_reg_wdata[0];
          `ALFA_REG_BASE: base_q     <= i_reg_wdata;
          `ALFA_REG_SIZE: size_q     <= i_reg_wdata[`ALFA_ID_W-1:0];
          default: ;
        endcase
      end
      // Hardware handshake overrides a software write in the same cycle
      if (i_frame_start) begin
        pc_ready_q   <= 1'b0;
        frame_done_q <= 1'b0;
      end else if (i_frame_done) begin
        frame_done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (i_reg_addr)
      `ALFA_REG_CTRL:   rd_mux = {31'd0, pc_ready_q};
      `ALFA_REG_BASE:   rd_mux = base_q;
      `ALFA_REG_SIZE:   rd_mux = {{(32-`ALFA_ID_W){1'b0}}, size_q};
      `ALFA_REG_STATUS: rd_mux = {30'd0, frame_done_q, i_enable};
      default:          rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge i_system_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_reg_rvalid <= 1'b0;
      o_reg_rdata  <= '0;
    end else begin
      o_reg_rvalid <= i_reg_rd;
      if (i_reg_rd) begin
        o_reg_rdata <= rd_mux;
      end
    end
  end

  assign o_pc_ready  = pc_ready_q;
  assign o_base_addr = base_q;
  assign o_pc_size   = size_q;

endmodule

`default_nettype wire

/* hdl/alfa_mem_map.sv */
// Memory address unit
// Latches base + ID * point size when control accepts a read or a write

`timescale 1ns/1ns
`default_nettype none

`include "alfa_macros.svh"

module alfa_mem_map (
  input  wire                   i_system_clk,
  input  wire                   i_rst_n,
  input  wire alfa_pkg::addr_t  i_base_addr,
  input  wire alfa_pkg::point_id_t i_ext_read_id,
  input  wire alfa_pkg::point_id_t i_ext_write_id,
  input  wire                   i_capture_read,
  input  wire                   i_capture_write,
  output alfa_pkg::addr_t       o_mem_addr
);

  alfa_pkg::point_id_t sel_id;
  alfa_pkg::addr_t     offset;
  alfa_pkg::addr_t     addr_q;

  // Write wins, same priority as control
  assign sel_id = i_capture_write ? i_ext_write_id : i_ext_read_id;
  assign offset = alfa_pkg::addr_t'(sel_id) * alfa_pkg::addr_t'(`ALFA_POINT_BYTES);

  // One register serves both fetch and store of a read-modify-write
  always_ff @(posedge i_system_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      addr_q <= '0;
    end else if (i_capture_read || i_capture_write) begin
      addr_q <= i_base_addr + offset;
    end
  end

  assign o_mem_addr = addr_q;

endmodule

`default_nettype wire

/* hdl/alfa_point_cache.sv */
// Point cache holding the last read point and the merged payload of a field write
// Loaded under strobes from the control FSM

`timescale 1ns/1ns
`default_nettype none

`include "alfa_macros.svh"

module alfa_point_cache (
  input  wire                        i_system_clk,
  input  wire                        i_rst_n,
  input  wire alfa_pkg::point_t      i_mem_rd_data,
  input  wire                        i_load_read,
  input  wire                        i_clear_read,
  input  wire                        i_load_write,
  input  wire                        i_capture_custom,
  input  wire [`ALFA_FIELD_W-1:0]    i_ext_write_custom_field,
  output alfa_pkg::point_t           o_read_point,
  output alfa_pkg::point_t           o_write_payload
);

  alfa_pkg::point_t read_q;
  alfa_pkg::point_t write_q;
  alfa_pkg::point_t merged;
  logic [`ALFA_FIELD_W-1:0] custom_q;

  // Read point, zeroed for an out-of-range read
  always_ff @(posedge i_system_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      read_q <= '0;
    end else if (i_clear_read) begin
      read_q <= '0;
    end else if (i_load_read) begin
      read_q <= i_mem_rd_data;
    end
  end

  // Fetched word with its custom field replaced
  always_comb begin
    merged        = i_mem_rd_data;
    merged.custom = custom_q;
  end

  always_ff @(posedge i_system_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      custom_q <= '0;
      write_q  <= '0;
    end else begin
      if (i_capture_custom) begin
        custom_q <= i_ext_write_custom_field;
      end
      if (i_load_write) begin
        write_q <= merged;
      end
    end
  end

  assign o_read_point    = read_q;
  assign o_write_payload = write_q;

endmodule

`default_nettype wire

/* hdl/alfa_control.sv */
// Control FSM of the access unit
// Sequences frame start/done, point reads and read-modify-write custom-field stores
// Range-checks IDs against the point-cloud size; a write beats a read in the same cycle

`timescale 1ns/1ns
`default_nettype none

module alfa_control (
  input  wire                      i_system_clk,
  input  wire                      i_rst_n,
  input  wire                      i_pc_ready,
  input  wire alfa_pkg::point_id_t i_pc_size,
  input  wire                      i_ext_read_ready,
  input  wire alfa_pkg::point_id_t i_ext_read_id,
  input  wire                      i_ext_write_valid,
  input  wire alfa_pkg::point_id_t i_ext_write_id,
  input  wire                      i_ext_done_processing,
  input  wire                      i_mem_rd_done,
  input  wire                      i_mem_wr_done,
  output logic                     o_ext_enable,
  output logic                     o_ext_write_ready,
  output logic                     o_ext_read_valid,
  output logic                     o_mem_rd_req,
  output logic                     o_mem_wr_req,
  output logic                     o_frame_start,
  output logic                     o_frame_done,
  output logic                     o_capture_read,
  output logic                     o_capture_write,
  output logic                     o_capture_custom,
  output logic                     o_load_read,
  output logic                     o_clear_read,
  output logic                     o_load_write
);

  alfa_pkg::ctrl_state_t state_q;
  alfa_pkg::ctrl_state_t state_d;
  // Out-of-range request, walks the FSM without a memory access
  logic skip_q;
  logic skip_d;
  logic in_run;
  logic rd_accept;
  logic wr_accept;
  logic rd_in_range;
  logic wr_in_range;

  assign in_run      = (state_q == alfa_pkg::RUN) && !i_ext_done_processing;
  assign wr_accept   = in_run && i_ext_write_valid;
  assign rd_accept   = in_run && i_ext_read_ready && !i_ext_write_valid;
  assign rd_in_range = i_ext_read_id < i_pc_size;
  assign wr_in_range = i_ext_write_id < i_pc_size;

  always_comb begin
    state_d = state_q;
    skip_d  = skip_q;
    case (state_q)
      alfa_pkg::IDLE: begin
        if (i_pc_ready) begin
          state_d = alfa_pkg::RUN;
        end
      end
      alfa_pkg::RUN: begin
        if (i_ext_done_processing) begin
          state_d = alfa_pkg::IDLE;
        end else if (wr_accept) begin
          state_d = alfa_pkg::WR_FETCH;
          skip_d  = !wr_in_range;
        end else if (rd_accept) begin
          state_d = alfa_pkg::RD_FETCH;
          skip_d  = !rd_in_range;
        end
      end
      alfa_pkg::RD_FETCH: begin
        state_d = skip_q ? alfa_pkg::RD_RESP : alfa_pkg::RD_WAIT;
      end
      alfa_pkg::RD_WAIT: begin
        if (i_mem_rd_done) begin
          state_d = alfa_pkg::RD_RESP;
        end
      end
      alfa_pkg::RD_RESP: state_d = alfa_pkg::RUN;
      alfa_pkg::WR_FETCH: begin
        state_d = skip_q ? alfa_pkg::RUN : alfa_pkg::WR_WAIT;
      end
      alfa_pkg::WR_WAIT: begin
        if (i_mem_rd_done) begin
          state_d = alfa_pkg::WR_STORE;
        end
      end
      alfa_pkg::WR_STORE: state_d = alfa_pkg::WR_DONE_WAIT;
      alfa_pkg::WR_DONE_WAIT: begin
        if (i_mem_wr_done) begin
          state_d = alfa_pkg::RUN;
        end
      end
      default: state_d = alfa_pkg::IDLE;
    endcase
  end

  always_ff @(posedge i_system_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= alfa_pkg::IDLE;
      skip_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      skip_q  <= skip_d;
    end
  end

  // Extension side
  assign o_ext_enable      = (state_q != alfa_pkg::IDLE);
  assign o_ext_write_ready = (state_q == alfa_pkg::RUN);
  assign o_ext_read_valid  = (state_q == alfa_pkg::RD_RESP);

  // Memory side
  assign o_mem_rd_req = !skip_q &&
                        ((state_q == alfa_pkg::RD_FETCH) || (state_q == alfa_pkg::WR_FETCH));
  assign o_mem_wr_req = (state_q == alfa_pkg::WR_STORE);

  // Monitor handshake
  assign o_frame_start = (state_q == alfa_pkg::IDLE) && i_pc_ready;
  assign o_frame_done  = (state_q == alfa_pkg::RUN) && i_ext_done_processing;

  // Address and cache strobes
  assign o_capture_read   = rd_accept;
  assign o_capture_write  = wr_accept;
  assign o_capture_custom = wr_accept;
  assign o_clear_read     = rd_accept && !rd_in_range;
  assign o_load_read      = (state_q == alfa_pkg::RD_WAIT) && i_mem_rd_done;
  assign o_load_write     = (state_q == alfa_pkg::WR_WAIT) && i_mem_rd_done;

endmodule

`default_nettype wire

/* hdl/alfa_unit.sv */
// Top level of the point-cloud access unit
// Register bus for software, extension-core port, and a request/done memory port

`timescale 1ns/1ns
`default_nettype none

`include "alfa_macros.svh"

module alfa_unit (
  input  wire                        i_system_clk,
  input  wire                        i_rst_n,
  // Register bus
  input  wire                        i_reg_wr,
  input  wire                        i_reg_rd,
  input  wire [3:0]                  i_reg_addr,
  input  wire [31:0]                 i_reg_wdata,
  output logic [31:0]                o_reg_rdata,
  output logic                       o_reg_rvalid,
  // Extension core
  input  wire                        i_ext_read_ready,
  input  wire alfa_pkg::point_id_t   i_ext_read_id,
  input  wire                        i_ext_write_valid,
  input  wire alfa_pkg::point_id_t   i_ext_write_id,
  input  wire [`ALFA_FIELD_W-1:0]    i_ext_write_custom_field,
  input  wire                        i_ext_done_processing,
  output logic                       o_ext_enable,
  output logic                       o_ext_write_ready,
  output logic                       o_ext_read_valid,
  output logic [`ALFA_FIELD_W-1:0]   o_ext_point_angle_h,
  output logic [`ALFA_FIELD_W-1:0]   o_ext_point_angle_v,
  output logic [`ALFA_FIELD_W-1:0]   o_ext_point_radius,
  output logic [`ALFA_FIELD_W-1:0]   o_ext_read_custom_field,
  output alfa_pkg::point_id_t        o_ext_pc_size,
  output alfa_pkg::addr_t            o_extmem_base_addr,
  // Point memory
  input  wire                        i_mem_rd_done,
  input  wire alfa_pkg::point_t      i_mem_rd_data,
  input  wire                        i_mem_wr_done,
  output logic                       o_mem_rd_req,
  output logic                       o_mem_wr_req,
  output alfa_pkg::addr_t            o_mem_addr,
  output alfa_pkg::point_t           o_mem_wr_data
);

  logic                pc_ready;
  logic                frame_start;
  logic                frame_done;
  logic                capture_read;
  logic                capture_write;
  logic                capture_custom;
  logic                load_read;
  logic                clear_read;
  logic                load_write;
  alfa_pkg::addr_t     base_addr;
  alfa_pkg::point_id_t pc_size;
  alfa_pkg::point_t    read_point;

  assign o_ext_point_angle_h     = read_point.angle_h;
  assign o_ext_point_angle_v     = read_point.angle_v;
  assign o_ext_point_radius      = read_point.radius;
  assign o_ext_read_custom_field = read_point.custom;
  assign o_ext_pc_size           = pc_size;
  assign o_extmem_base_addr      = base_addr;

  alfa_monitor u_monitor (
    .i_system_clk  (i_system_clk),
    .i_rst_n       (i_rst_n),
    .i_reg_wr      (i_reg_wr),
    .i_reg_rd      (i_reg_rd),
    .i_reg_addr    (i_reg_addr),
    .i_reg_wdata   (i_reg_wdata),
    .i_frame_start (frame_start),
    .i_frame_done  (frame_done),
    .i_enable      (o_ext_enable),
    .o_reg_rdata   (o_reg_rdata),
    .o_reg_rvalid  (o_reg_rvalid),
    .o_pc_ready    (pc_ready),
    .o_base_addr   (base_addr),
    .o_pc_size     (pc_size)
  );

  alfa_mem_map u_mem_map (
    .i_system_clk    (i_system_clk),
    .i_rst_n         (i_rst_n),
    .i_base_addr     (base_addr),
    .i_ext_read_id   (i_ext_read_id),
    .i_ext_write_id  (i_ext_write_id),
    .i_capture_read  (capture_read),
    .i_capture_write (capture_write),
    .o_mem_addr      (o_mem_addr)
  );

  alfa_point_cache u_point_cache (
    .i_system_clk             (i_system_clk),
    .i_rst_n                  (i_rst_n),
    .i_mem_rd_data            (i_mem_rd_data),
    .i_load_read              (load_read),
    .i_clear_read             (clear_read),
    .i_load_write             (load_write),
    .i_capture_custom         (capture_custom),
    .i_ext_write_custom_field (i_ext_write_custom_field),
    .o_read_point             (read_point),
    .o_write_payload          (o_mem_wr_data)
  );

  alfa_control u_control (
    .i_system_clk          (i_system_clk),
    .i_rst_n               (i_rst_n),
    .i_pc_ready            (pc_ready),
    .i_pc_size             (pc_size),
    .i_ext_read_ready      (i_ext_read_ready),
    .i_ext_read_id         (i_ext_read_id),
    .i_ext_write_valid     (i_ext_write_valid),
    .i_ext_write_id        (i_ext_write_id),
    .i_ext_done_processing (i_ext_done_processing),
    .i_mem_rd_done         (i_mem_rd_done),
    .i_mem_wr_done         (i_mem_wr_done),
    .o_ext_enable          (o_ext_enable),
    .o_ext_write_ready     (o_ext_write_ready),
    .o_ext_read_valid      (o_ext_read_valid),
    .o_mem_rd_req          (o_mem_rd_req),
    .o_mem_wr_req          (o_mem_wr_req),
    .o_frame_start         (frame_start),
    .o_frame_done          (frame_done),
    .o_capture_read        (capture_read),
    .o_capture_write       (capture_write),
    .o_capture_custom      (capture_custom),
    .o_load_read           (load_read),
    .o_clear_read          (clear_read),
    .o_load_write          (load_write)
  );

endmodule

`default_nettype wire

/* testbench/alfa_unit_props.sv */
// Concurrent assertions on the control FSM's memory and extension handshakes
// Bound into every alfa_control instance

`timescale 1ns/1ns
`default_nettype none

module alfa_unit_props (
  input wire i_clk,
  input wire i_rst_n,
  input wire i_mem_rd_req,
  input wire i_mem_wr_req,
  input wire i_mem_rd_done,
  input wire i_mem_wr_done,
  input wire i_ext_read_valid,
  input wire i_ext_write_ready
);

  // High from a memory request until its done pulse
  logic busy_q;
  int fail_count = 0;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy_q <= 1'b0;
    end else if (i_mem_rd_req || i_mem_wr_req) begin
      busy_q <= 1'b1;
    end else if (i_mem_rd_done || i_mem_wr_done) begin
      busy_q <= 1'b0;
    end
  end

  req_exclusive: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      (i_mem_rd_req || i_mem_wr_req) |-> !busy_q && !(i_mem_rd_req && i_mem_wr_req)
  ) else begin
    fail_count++;
    $error("Memory request overlaps another memory access");
  end

  read_valid_pulse: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_ext_read_valid |=> !i_ext_read_valid
  ) else begin
    fail_count++;
    $error("o_ext_read_valid held for more than one cycle");
  end

  ready_while_busy: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      (busy_q || i_mem_rd_req || i_mem_wr_req) |-> !i_ext_write_ready
  ) else begin
    fail_count++;
    $error("o_ext_write_ready high during a memory access");
  end

endmodule

bind alfa_control alfa_unit_props props_i (
  .i_clk             (i_system_clk),
  .i_rst_n           (i_rst_n),
  .i_mem_rd_req      (o_mem_rd_req),
  .i_mem_wr_req      (o_mem_wr_req),
  .i_mem_rd_done     (i_mem_rd_done),
  .i_mem_wr_done     (i_mem_wr_done),
  .i_ext_read_valid  (o_ext_read_valid),
  .i_ext_write_ready (o_ext_write_ready)
);

`default_nettype wire

/* testbench/tb_alfa_unit.sv */
// Directed testbench for the point-cloud access unit
// Models the point memory with LFSR-chosen latency and checks registers, frames,
// point reads, custom-field writes and range checks

`timescale 1ns/1ns
`default_nettype none

`include "alfa_macros.svh"

module tb_alfa_unit;

  localparam logic [31:0] BASE_ADDR = 32'h0001_0000;
  localparam int MEM_POINTS = 64;
  // Upper bits must be dropped by the 19-bit SIZE register
  localparam logic [31:0] SIZE_WRITE = 32'hfff8_0028;
  localparam int PC_SIZE = 40;
  localparam int WAIT_LIMIT = 16;
  // Cycle budget per operation summed into the watchdog limit
  localparam int REG_OPS = 16;
  localparam int READ_OPS = 12;
  localparam int WRITE_OPS = 4;
  localparam int WATCHDOG_CYCLES = 10 + REG_OPS * 4 + READ_OPS * 12 + WRITE_OPS * 20 + 40 + 200;

  logic i_system_clk;
  logic i_rst_n;
  logic i_reg_wr;
  logic i_reg_rd;
  logic [3:0] i_reg_addr;
  logic [31:0] i_reg_wdata;
  logic [31:0] o_reg_rdata;
  logic o_reg_rvalid;
  logic i_ext_read_ready;
  alfa_pkg::point_id_t i_ext_read_id;
  logic i_ext_write_valid;
  alfa_pkg::point_id_t i_ext_write_id;
  logic [`ALFA_FIELD_W-1:0] i_ext_write_custom_field;
  logic i_ext_done_processing;
  logic o_ext_enable;
  logic o_ext_write_ready;
  logic o_ext_read_valid;
  logic [`ALFA_FIELD_W-1:0] o_ext_point_angle_h;
  logic [`ALFA_FIELD_W-1:0] o_ext_point_angle_v;
  logic [`ALFA_FIELD_W-1:0] o_ext_point_radius;
  logic [`ALFA_FIELD_W-1:0] o_ext_read_custom_field;
  alfa_pkg::point_id_t o_ext_pc_size;
  alfa_pkg::addr_t o_extmem_base_addr;
  logic i_mem_rd_done;
  alfa_pkg::point_t i_mem_rd_data;
  logic i_mem_wr_done;
  logic o_mem_rd_req;
  logic o_mem_wr_req;
  alfa_pkg::addr_t o_mem_addr;
  alfa_pkg::point_t o_mem_wr_data;

  alfa_pkg::point_t mem [MEM_POINTS];
  logic [2:0] pend_cnt;
  logic pend_wr;
  logic [5:0] pend_idx;
  alfa_pkg::point_t pend_data;
  logic [31:0] lfsr_q;
  int checks;
  int errors;

  alfa_unit dut_i (.*);

  always #10 i_system_clk = ~i_system_clk;

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  task automatic expect_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  // Point memory model answering 1 to 4 cycles after a request
  always @(posedge i_system_clk) begin : mem_model
    logic b0;
    logic b1;
    i_mem_rd_done <= 1'b0;
    i_mem_wr_done <= 1'b0;
    if (o_mem_rd_req || o_mem_wr_req) begin
      expect_true(o_mem_addr >= BASE_ADDR && o_mem_addr < BASE_ADDR + MEM_POINTS * 8,
                  "memory request outside the point memory");
      b0 = lfsr_bit();
      b1 = lfsr_bit();
      pend_cnt  <= {1'b0, b1, b0} + 3'd1;
      pend_wr   <= o_mem_wr_req;
      pend_idx  <= 6'((o_mem_addr - BASE_ADDR) >> 3);
      pend_data <= o_mem_wr_data;
    end else if (pend_cnt != 3'd0) begin
      pend_cnt <= pend_cnt - 3'd1;
      if (pend_cnt == 3'd1) begin
        if (pend_wr) begin
          mem[pend_idx] <= pend_data;
          i_mem_wr_done <= 1'b1;
        end else begin
          i_mem_rd_data <= mem[pend_idx];
          i_mem_rd_done <= 1'b1;
        end
      end
    end
  end

  task automatic write_register(input logic [3:0] addr, input logic [31:0] data);
    @(posedge i_system_clk);
    i_reg_wr    <= 1'b1;
    i_reg_addr  <= addr;
    i_reg_wdata <= data;
    @(posedge i_system_clk);
    i_reg_wr <= 1'b0;
  endtask

  task automatic expect_register(input logic [3:0] addr, input logic [31:0] exp, input string name);
    int n;
    @(posedge i_system_clk);
    i_reg_rd   <= 1'b1;
    i_reg_addr <= addr;
    @(posedge i_system_clk);
    i_reg_rd <= 1'b0;
    n = 0;
    while (!o_reg_rvalid && n < 4) begin
      @(posedge i_system_clk);
      n++;
    end
    expect_true(o_reg_rvalid, "no read data returned on the register bus");
    expect_equal(name, o_reg_rdata, exp);
  endtask

  task automatic ext_read(input alfa_pkg::point_id_t id);
    alfa_pkg::point_t exp;
    logic in_range;
    int n;
    in_range = id < PC_SIZE;
    exp = '0;
    if (in_range) begin
      exp = mem[id];
    end
    @(posedge i_system_clk);
    i_ext_read_ready <= 1'b1;
    i_ext_read_id    <= id;
    @(posedge i_system_clk);
    i_ext_read_ready <= 1'b0;
    @(posedge i_system_clk);
    expect_equal("o_mem_rd_req", o_mem_rd_req, in_range);
    if (in_range) begin
      expect_equal("o_mem_addr", o_mem_addr, BASE_ADDR + 32'(id) * `ALFA_POINT_BYTES);
    end
    n = 0;
    while (!o_ext_read_valid && n < WAIT_LIMIT) begin
      @(posedge i_system_clk);
      n++;
      expect_true(!o_mem_rd_req && !o_mem_wr_req, "extra memory request during a read");
    end
    expect_true(o_ext_read_valid, "o_ext_read_valid never came");
    if (!in_range) begin
      expect_equal("out-of-range read delay", n, 1);
    end
    expect_equal("o_ext_point_angle_h", o_ext_point_angle_h, exp.angle_h);
    expect_equal("o_ext_point_angle_v", o_ext_point_angle_v, exp.angle_v);
    expect_equal("o_ext_point_radius", o_ext_point_radius, exp.radius);
    expect_equal("o_ext_read_custom_field", o_ext_read_custom_field, exp.custom);
  endtask

  task automatic ext_write(input alfa_pkg::point_id_t id, input logic [15:0] field);
    alfa_pkg::point_t exp;
    logic in_range;
    int n;
    in_range = id < PC_SIZE;
    @(posedge i_system_clk);
    i_ext_write_valid        <= 1'b1;
    i_ext_write_id           <= id;
    i_ext_write_custom_field <= field;
    @(posedge i_system_clk);
    i_ext_write_valid <= 1'b0;
    @(posedge i_system_clk);
    expect_equal("o_ext_write_ready", o_ext_write_ready, 1'b0);
    expect_equal("o_mem_rd_req", o_mem_rd_req, in_range);
    if (in_range) begin
      expect_equal("o_mem_addr", o_mem_addr, BASE_ADDR + 32'(id) * `ALFA_POINT_BYTES);
      exp = mem[id];
      exp.custom = field;
      n = 0;
      while (!o_mem_wr_req && n < WAIT_LIMIT) begin
        @(posedge i_system_clk);
        n++;
      end
      expect_true(o_mem_wr_req, "store request never came");
      expect_equal("o_mem_addr", o_mem_addr, BASE_ADDR + 32'(id) * `ALFA_POINT_BYTES);
      expect_equal("o_mem_wr_data", o_mem_wr_data, exp);
    end
    n = 0;
    while (!o_ext_write_ready && n < WAIT_LIMIT) begin
      @(posedge i_system_clk);
      n++;
      expect_true(in_range || (!o_mem_rd_req && !o_mem_wr_req),
                  "memory request for an out-of-range write");
    end
    expect_true(o_ext_write_ready, "o_ext_write_ready did not return");
    if (in_range) begin
      expect_equal("memory custom field", mem[id].custom, field);
    end else begin
      expect_equal("out-of-range write delay", n, 1);
    end
  endtask

  task automatic verify_registers();
    expect_register(`ALFA_REG_CTRL, 32'd0, "CTRL");
    expect_register(`ALFA_REG_BASE, 32'd0, "BASE");
    expect_register(`ALFA_REG_SIZE, 32'd0, "SIZE");
    expect_register(`ALFA_REG_STATUS, 32'd0, "STATUS");
    write_register(`ALFA_REG_BASE, BASE_ADDR);
    write_register(`ALFA_REG_SIZE, SIZE_WRITE);
    write_register(`ALFA_REG_STATUS, 32'hffff_ffff);
    expect_register(`ALFA_REG_BASE, BASE_ADDR, "BASE");
    expect_register(`ALFA_REG_SIZE, PC_SIZE, "SIZE");
    expect_register(`ALFA_REG_STATUS, 32'd0, "STATUS");
    expect_equal("o_extmem_base_addr", o_extmem_base_addr, BASE_ADDR);
    expect_equal("o_ext_pc_size", o_ext_pc_size, PC_SIZE);
  endtask

  task automatic start_frame();
    int n;
    write_register(`ALFA_REG_CTRL, 32'd1);
    n = 0;
    while (!o_ext_enable && n < WAIT_LIMIT) begin
      @(posedge i_system_clk);
      n++;
    end
    expect_true(o_ext_enable, "o_ext_enable did not rise after pc_ready");
    expect_register(`ALFA_REG_CTRL, 32'd0, "CTRL");
    expect_register(`ALFA_REG_STATUS, 32'd1, "STATUS");
  endtask

  task automatic end_frame();
    int n;
    @(posedge i_system_clk);
    i_ext_done_processing <= 1'b1;
    @(posedge i_system_clk);
    i_ext_done_processing <= 1'b0;
    n = 0;
    while (o_ext_enable && n < WAIT_LIMIT) begin
      @(posedge i_system_clk);
      n++;
    end
    expect_equal("o_ext_enable", o_ext_enable, 1'b0);
    expect_register(`ALFA_REG_STATUS, 32'd2, "STATUS");
    // A read outside the frame gets no answer
    @(posedge i_system_clk);
    i_ext_read_ready <= 1'b1;
    i_ext_read_id    <= 19'd3;
    @(posedge i_system_clk);
    i_ext_read_ready <= 1'b0;
    repeat (8) begin
      @(posedge i_system_clk);
      expect_true(!o_ext_read_valid && !o_mem_rd_req, "read request served after frame done");
    end
  endtask

  initial begin
    i_system_clk = 1'b0;
    i_rst_n = 1'b0;
    i_reg_wr = 1'b0;
    i_reg_rd = 1'b0;
    i_reg_addr = '0;
    i_reg_wdata = '0;
    i_ext_read_ready = 1'b0;
    i_ext_read_id = '0;
    i_ext_write_valid = 1'b0;
    i_ext_write_id = '0;
    i_ext_write_custom_field = '0;
    i_ext_done_processing = 1'b0;
    i_mem_rd_done = 1'b0;
    i_mem_rd_data = '0;
    i_mem_wr_done = 1'b0;
    pend_cnt = '0;
    pend_wr = 1'b0;
    pend_idx = '0;
    pend_data = '0;
    lfsr_q = 32'h3b9c;
    checks = 0;
    errors = 0;
    // Every field depends on the full point index
    for (int i = 0; i < MEM_POINTS; i++) begin
      mem[i] = {16'(i * 3 + 16'h1000), 16'(i ^ 16'h0a50), 16'(16'hffff - i), 16'(i * 7)};
    end
    repeat (10) @(posedge i_system_clk);
    i_rst_n <= 1'b1;

    verify_registers();
    start_frame();
    ext_read(19'd0);
    ext_read(19'd1);
    ext_read(19'd7);
    ext_read(19'd39);
    ext_read(19'd20);
    ext_read(19'd33);
    ext_write(19'd5, 16'hbeef);
    ext_write(19'd39, 16'h1234);
    ext_write(19'd12, 16'h0000);
    ext_read(19'd5);
    expect_equal("o_ext_read_custom_field", o_ext_read_custom_field, 16'hbeef);
    ext_read(19'd39);
    expect_equal("o_ext_read_custom_field", o_ext_read_custom_field, 16'h1234);
    ext_read(19'd45);
    ext_read(19'h7ffff);
    ext_write(19'd40, 16'h5a5a);
    end_frame();

    $display("Checks: %0d, errors: %0d, property failures: %0d", checks, errors,
             dut_i.u_control.props_i.fail_count);
    if (errors == 0 && dut_i.u_control.props_i.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_system_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Checks: %0d, errors: %0d, property failures: %0d", checks, errors,
             dut_i.u_control.props_i.fail_count);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* alfa_unit.f */
+incdir+hdl
hdl/alfa_pkg.sv
hdl/alfa_monitor.sv
hdl/alfa_mem_map.sv
hdl/alfa_point_cache.sv
hdl/alfa_control.sv
hdl/alfa_unit.sv
testbench/alfa_unit_props.sv
testbench/tb_alfa_unit.sv
